/* fma_unit.f */
hdl/bf16_pkg.sv
hdl/fma_ctrl_pkg.sv
hdl/fma_control.sv
hdl/fma_classify.sv
hdl/fma_multiply.sv
hdl/fma_align_add.sv
hdl/fma_normalize_round.sv
hdl/fma_unit.sv
test/fma_unit_assertions.sv
test/fma_unit_tb.sv

/* hdl/bf16_pkg.sv */
`default_nettype none

package bf16_pkg;

    ////////////////////////////////////////////////////////////////////////
    // bf16 field layout
    ////////////////////////////////////////////////////////////////////////

    // sign, 8 exponent bits, 7 stored mantissa bits
    localparam int BF16_EXP_BITS = 8;
    localparam int BF16_MAN_BITS = 7;
    localparam int BF16_BIAS     = 127;

    // product and addend line up in this many bits
    localparam int WIDE_MAN_BITS = 32;

    ////////////////////////////////////////////////////////////////////////
    // datapath vectors
    ////////////////////////////////////////////////////////////////////////

    // raw operand as it arrives
    typedef logic [15:0] bf16_t;

    // result word, fp32 layout
    typedef logic [31:0] fp32_t;

    // working exponent, signed
    // two extra bits so overflow above 255 and underflow below 0 stay visible
    typedef logic signed [BF16_EXP_BITS+1:0] exp_t;

    // 8x8 product with both hidden bits
    typedef logic [2*(BF16_MAN_BITS+1)-1:0] prod_man_t;

    // left-justified product or addend
    typedef logic [WIDE_MAN_BITS-1:0] wide_man_t;

    // carry bit on top, ground bit at the bottom
    typedef logic [WIDE_MAN_BITS+1:0] sum_man_t;

    // leading zeros below the carry bit, 0 to 33
    typedef logic [5:0] lzc_t;

    // canonical quiet nan
    localparam fp32_t CANON_QNAN = 32'h7FC0_0000;

endpackage

`default_nettype wire

/* hdl/fma_align_add.sv */
`timescale 1ns/1ps
`default_nettype none

module fma_align_add (
    input  logic                gated_clk,
    input  bf16_pkg::wide_man_t prod_man_i,
    input  bf16_pkg::exp_t      prod_exp_i,
    input  logic                prod_sign_i,
    input  bf16_pkg::bf16_t     c_i,
    output bf16_pkg::sum_man_t  sum_man_o,
    output bf16_pkg::exp_t      sum_exp_o,
    output logic                sum_sign_o
);
    import bf16_pkg::*;

    exp_t      c_exp;
    exp_t      big_exp;
    exp_t      exp_n;
    wide_man_t c_man;
    wide_man_t p_man;
    // one carry bit over the aligned width
    logic [WIDE_MAN_BITS:0] raw_sum;
    sum_man_t  sum;
    logic      sign_n;

    ////////////////////////////////////////////////////////////////////////
    // alignment
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        c_exp = exp_t'({2'b00, c_i[BF16_MAN_BITS +: BF16_EXP_BITS]});
        // hidden bit only for a non-zero c
        c_man = {|c_i[BF16_MAN_BITS +: BF16_EXP_BITS], c_i[BF16_MAN_BITS-1:0],
                 {(WIDE_MAN_BITS-BF16_MAN_BITS-1){1'b0}}};
        p_man = prod_man_i;
        // smaller exponent shifts right, bits below 32 are lost
        if (c_exp < prod_exp_i) begin
            c_man   = c_man >> (prod_exp_i - c_exp);
            big_exp = prod_exp_i;
        end else begin
            p_man   = p_man >> (c_exp - prod_exp_i);
            big_exp = c_exp;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // add or subtract magnitudes
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (prod_sign_i != c_i[15]) begin
            // larger magnitude keeps its sign
            if (p_man >= c_man) begin
                raw_sum = {1'b0, p_man - c_man};
                sign_n  = prod_sign_i;
            end else begin
                raw_sum = {1'b0, c_man - p_man};
                sign_n  = c_i[15];
            end
        end else begin
            raw_sum = {1'b0, p_man} + {1'b0, c_man};
            sign_n  = prod_sign_i;
        end
        // ground bit catches the bit dropped on carry
        sum   = {raw_sum, 1'b0};
        exp_n = big_exp;
        if (sum[WIDE_MAN_BITS+1]) begin
            sum   = sum >> 1;
            exp_n = big_exp + exp_t'(1);
        end else if (sum == '0) begin
            exp_n = '0;
        end
    end

    // stage 2
    always_ff @(posedge gated_clk) begin
        sum_man_o  <= sum;
        sum_exp_o  <= exp_n;
        sum_sign_o <= sign_n;
    end

endmodule

`default_nettype wire

/* hdl/fma_classify.sv */
`timescale 1ns/1ps
`default_nettype none

module fma_classify (
    input  logic            gated_clk,
    input  logic            reset,
    input  bf16_pkg::bf16_t op_a_i,
    input  bf16_pkg::bf16_t op_b_i,
    input  bf16_pkg::bf16_t op_c_i,
    input  logic            negate_a_i,
    input  logic            negate_c_i,
    input  logic            force_a_one_i,
    input  logic            force_c_zero_i,
    output bf16_pkg::bf16_t a_o,
    output bf16_pkg::bf16_t b_o,
    output bf16_pkg::bf16_t c_o,
    output logic            special_o,
    output bf16_pkg::fp32_t special_result_o,
    output logic            invalid_o
);
    import bf16_pkg::*;
    import fma_ctrl_pkg::*;

    // stages 1 and 2, so the special result meets the datapath at stage 3
    localparam int SPECIAL_DELAY = PIPE_DEPTH - 2;
    // +1.0
    localparam bf16_t BF16_ONE = {1'b0, BF16_EXP_BITS'(BF16_BIAS), BF16_MAN_BITS'(0)};

    // stage 0 operands
    bf16_t a_q;
    bf16_t b_q;
    bf16_t c_q;
    // after sign flips and forced constants
    bf16_t a_mod;
    bf16_t c_mod;
    bf16_t c_s1;
    logic  nan_a, nan_b, nan_c;
    logic  inf_a, inf_b, inf_c;
    logic  zero_a, zero_b;
    logic  prod_sign;
    logic  invalid;
    logic  special;
    fp32_t special_result;
    logic [SPECIAL_DELAY-1:0] special_d;
    logic [SPECIAL_DELAY-1:0] invalid_d;
    fp32_t result_d [SPECIAL_DELAY];

    // stage 0, loaded every cycle
    always_ff @(posedge gated_clk) begin
        a_q <= op_a_i;
        b_q <= op_b_i;
        c_q <= op_c_i;
    end

    always_comb begin
        a_mod = force_a_one_i ? BF16_ONE : {a_q[15] ^ negate_a_i, a_q[14:0]};
        // subnormal c counts as +0
        if (force_c_zero_i || (c_q[14:7] == '0 && c_q[6:0] != '0)) begin
            c_mod = '0;
        end else begin
            c_mod = {c_q[15] ^ negate_c_i, c_q[14:0]};
        end
    end

    // exponent in [14:7], stored mantissa in [6:0]
    always_comb begin
        nan_a  = (&a_mod[14:7]) && (|a_mod[6:0]);
        nan_b  = (&b_q[14:7])   && (|b_q[6:0]);
        nan_c  = (&c_mod[14:7]) && (|c_mod[6:0]);
        inf_a  = (&a_mod[14:7]) && !(|a_mod[6:0]);
        inf_b  = (&b_q[14:7])   && !(|b_q[6:0]);
        inf_c  = (&c_mod[14:7]) && !(|c_mod[6:0]);
        // zero or subnormal
        zero_a = (a_mod[14:7] == '0);
        zero_b = (b_q[14:7] == '0);
        prod_sign = a_mod[15] ^ b_q[15];
        // inf-inf decided from the modified signs
        invalid = nan_a || nan_b || nan_c || (inf_a && zero_b) || (inf_b && zero_a)
                  || ((inf_a || inf_b) && inf_c && (prod_sign != c_mod[15]));
        special = invalid || inf_a || inf_b || inf_c || zero_a || zero_b;
        if (invalid) begin
            special_result = CANON_QNAN;
        end else if (inf_a || inf_b) begin
            special_result = {prod_sign, 8'hFF, 23'h0};
        end else if (inf_c) begin
            special_result = {c_mod[15], 8'hFF, 23'h0};
        end else begin
            // zero product, c passes through widened
            special_result = {c_mod, 16'h0000};
        end
    end

    // c reaches the adder one stage after a and b reach the multiplier
    always_ff @(posedge gated_clk) begin
        c_s1 <= c_mod;
    end

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            special_d <= '0;
            invalid_d <= '0;
        end else begin
            special_d <= {special_d[SPECIAL_DELAY-2:0], special};
            invalid_d <= {invalid_d[SPECIAL_DELAY-2:0], invalid};
        end
    end

    always_ff @(posedge gated_clk) begin
        result_d[0] <= special_result;
        for (int i = 1; i < SPECIAL_DELAY; i++) begin
            result_d[i] <= result_d[i-1];
        end
    end

    assign a_o              = a_mod;
    assign b_o              = b_q;
    assign c_o              = c_s1;
    assign special_o        = special_d[SPECIAL_DELAY-1];
    assign invalid_o        = invalid_d[SPECIAL_DELAY-1];
    assign special_result_o = result_d[SPECIAL_DELAY-1];

endmodule

`default_nettype wire

/* hdl/fma_control.sv */
`timescale 1ns/1ps
`default_nettype none

module fma_control (
    input  logic                  gated_clk,
    input  logic                  reset,
    input  logic                  in_valid_i,
    input  fma_ctrl_pkg::fma_op_e op_code_i,
    input  logic                  out_credit_i,
    output logic                  in_credit_o,
    output logic                  negate_a_o,
    output logic                  negate_c_o,
    output logic                  force_a_one_o,
    output logic                  force_c_zero_o,
    output logic                  s3_valid_o,
    output logic                  out_valid_o
);
    import fma_ctrl_pkg::*;

    // sink slots still free and not yet granted upstream
    credit_cnt_t credit_cnt;
    // bit n set when stage n holds a live item
    logic [PIPE_DEPTH-1:0] valid_sr;
    // decoded operand modifiers, ahead of stage 0
    logic neg_a;
    logic neg_c;
    logic one_a;
    logic zero_c;

    ////////////////////////////////////////////////////////////////////////
    // credits
    ////////////////////////////////////////////////////////////////////////

    // one grant per cycle while a slot is left
    assign in_credit_o = (credit_cnt != '0);

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            credit_cnt <= credit_cnt_t'(RESULT_CREDITS);
        end else begin
            // grant and returned slot in the same cycle cancel
            case ({in_credit_o, out_credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // valid pipeline
    ////////////////////////////////////////////////////////////////////////

    // never stalls
    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[PIPE_DEPTH-2:0], in_valid_i};
        end
    end

    // stage 2 item gets written into the output register
    assign s3_valid_o  = valid_sr[PIPE_DEPTH-2];
    assign out_valid_o = valid_sr[PIPE_DEPTH-1];

    ////////////////////////////////////////////////////////////////////////
    // operation decode
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        neg_a  = 1'b0;
        neg_c  = 1'b0;
        one_a  = 1'b0;
        zero_c = 1'b0;
        case (op_code_i)
            FMSUB:  neg_c = 1'b1;
            FNMSUB: neg_a = 1'b1;
            FNMADD: begin
                neg_a = 1'b1;
                neg_c = 1'b1;
            end
            // a becomes +1.0
            ADD:    one_a = 1'b1;
            SUB: begin
                one_a = 1'b1;
                neg_c = 1'b1;
            end
            // c becomes +0
            MUL:    zero_c = 1'b1;
            default: ;
        endcase
    end

    // same edge as the stage 0 operand registers
    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            negate_a_o     <= 1'b0;
            negate_c_o     <= 1'b0;
            force_a_one_o  <= 1'b0;
            force_c_zero_o <= 1'b0;
        end else begin
            negate_a_o     <= neg_a;
            negate_c_o     <= neg_c;
            force_a_one_o  <= one_a;
            force_c_zero_o <= zero_c;
        end
    end

endmodule

`default_nettype wire

/* hdl/fma_ctrl_pkg.sv */
`default_nettype none

package fma_ctrl_pkg;

    // risc-v style operation codes
    // unknown codes run as fmadd
    typedef enum logic [3:0] {
        ADD    = 4'd4,
        MUL    = 4'd5,
        SUB    = 4'd6,
        FMADD  = 4'd7,
        FMSUB  = 4'd8,
        FNMADD = 4'd9,
        FNMSUB = 4'd10
    } fma_op_e;

    // invalid, overflow, underflow, inexact from msb down
    typedef logic [3:0] fpcsr_t;

    // register stages from operand capture to result
    localparam int PIPE_DEPTH = 4;

    // result slots held by the sink
    localparam int RESULT_CREDITS = 4;

    // counts up to RESULT_CREDITS
    typedef logic [2:0] credit_cnt_t;

endpackage

`default_nettype wire

/* hdl/fma_multiply.sv */
`timescale 1ns/1ps
`default_nettype none

module fma_multiply (
    input  logic                gated_clk,
    input  bf16_pkg::bf16_t     a_i,
    input  bf16_pkg::bf16_t     b_i,
    output bf16_pkg::wide_man_t prod_man_o,
    output bf16_pkg::exp_t      prod_exp_o,
    output logic                prod_sign_o
);
    import bf16_pkg::*;

    // mantissas with hidden bit
    logic [BF16_MAN_BITS:0] man_a;
    logic [BF16_MAN_BITS:0] man_b;
    exp_t      exp_a;
    exp_t      exp_b;
    prod_man_t prod;
    exp_t      prod_exp;

    always_comb begin
        man_a    = {1'b1, a_i[BF16_MAN_BITS-1:0]};
        man_b    = {1'b1, b_i[BF16_MAN_BITS-1:0]};
        exp_a    = exp_t'({2'b00, a_i[BF16_MAN_BITS +: BF16_EXP_BITS]});
        exp_b    = exp_t'({2'b00, b_i[BF16_MAN_BITS +: BF16_EXP_BITS]});
        prod     = man_a * man_b;
        prod_exp = exp_a + exp_b - exp_t'(BF16_BIAS);
        // no normal product here, flush to zero
        if (prod_exp <= 0) begin
            prod     = '0;
            prod_exp = '0;
        end
        // 1x.xxx bumps the exponent, 01.xxx shifts up one
        if (prod[$bits(prod_man_t)-1]) begin
            prod_exp = prod_exp + exp_t'(1);
        end else begin
            prod = prod << 1;
        end
    end

    // stage 1
    always_ff @(posedge gated_clk) begin
        prod_man_o  <= {prod, {(WIDE_MAN_BITS-$bits(prod_man_t)){1'b0}}};
        prod_exp_o  <= prod_exp;
        prod_sign_o <= a_i[15] ^ b_i[15];
    end

endmodule

`default_nettype wire

/* hdl/fma_normalize_round.sv */
`timescale 1ns/1ps
`default_nettype none

module fma_normalize_round (
    input  logic                 gated_clk,
    input  logic                 reset,
    input  logic                 s3_valid_i,
    input  bf16_pkg::sum_man_t   sum_man_i,
    input  bf16_pkg::exp_t       sum_exp_i,
    input  logic                 sum_sign_i,
    input  logic                 special_i,
    input  bf16_pkg::fp32_t      special_result_i,
    input  logic                 invalid_i,
    output bf16_pkg::fp32_t      result_o,
    output fma_ctrl_pkg::fpcsr_t fpcsr_o
);
    import bf16_pkg::*;

    // leading one sits at bit 32 after the shift
    // 23 fraction bits under it, then guard and round
    localparam int GRD_POS = WIDE_MAN_BITS - 24;
    localparam int EXP_MAX = (1 << BF16_EXP_BITS) - 1;

    lzc_t        lzc;
    sum_man_t    norm;
    exp_t        norm_exp;
    exp_t        final_exp;
    logic [23:0] man_rnd;
    logic        guard;
    logic        round;
    logic        sticky;
    logic        ovf;
    logic        unf;
    logic        inx;
    fp32_t       regular;
    fp32_t       result_n;

    // leading zeros below the carry bit, highest set bit wins
    always_comb begin
        lzc = lzc_t'(WIDE_MAN_BITS + 1);
        for (int i = 0; i <= WIDE_MAN_BITS; i++) begin
            if (sum_man_i[i]) begin
                lzc = lzc_t'(WIDE_MAN_BITS - i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // normalize and round to nearest even
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        norm     = sum_man_i << lzc;
        norm_exp = sum_exp_i - exp_t'(lzc);
        guard    = norm[GRD_POS];
        round    = norm[GRD_POS-1];
        sticky   = |norm[GRD_POS-2:0];
        // tie goes up only on an odd lsb
        man_rnd  = {1'b0, norm[WIDE_MAN_BITS-1:GRD_POS+1]}
                   + 24'(guard & (round | sticky | norm[GRD_POS+1]));
        final_exp = norm_exp;
        // all-ones fraction rolled over, fraction already zero
        if (man_rnd[23]) begin
            final_exp = norm_exp + exp_t'(1);
        end

        ovf = 1'b0;
        unf = 1'b0;
        inx = guard | round | sticky;
        if (final_exp >= exp_t'(EXP_MAX)) begin
            ovf     = 1'b1;
            regular = {sum_sign_i, 8'hFF, 23'h0};
        end else if (final_exp <= 0) begin
            // too small, flushed to signed zero
            unf     = 1'b1;
            inx     = 1'b1;
            regular = {sum_sign_i, 31'h0};
        end else begin
            regular = {sum_sign_i, final_exp[7:0], man_rnd[22:0]};
        end

        if (special_i) begin
            result_n = special_result_i;
            ovf      = 1'b0;
            unf      = 1'b0;
            inx      = 1'b0;
        end else begin
            result_n = regular;
        end
        // no subnormal leaves the unit
        if (result_n[30:23] == 8'h00 && result_n[22:0] != '0) begin
            result_n = '0;
        end
    end

    // stage 3, only live items
    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            result_o <= '0;
            fpcsr_o  <= '0;
        end else if (s3_valid_i) begin
            result_o <= result_n;
            fpcsr_o  <= {invalid_i, ovf, unf, inx};
        end
    end

endmodule

`default_nettype wire

/* hdl/fma_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fma_unit (
    input  logic                  gated_clk,
    input  logic                  reset,
    input  logic                  in_valid_i,
    input  bf16_pkg::bf16_t       op_a_i,
    input  bf16_pkg::bf16_t       op_b_i,
    input  bf16_pkg::bf16_t       op_c_i,
    input  fma_ctrl_pkg::fma_op_e op_code_i,
    output logic                  in_credit_o,
    input  logic                  out_credit_i,
    output logic                  out_valid_o,
    output bf16_pkg::fp32_t       result_o,
    output fma_ctrl_pkg::fpcsr_t  fpcsr_o
);
    import bf16_pkg::*;

    // stage 0 modifiers
    logic      negate_a;
    logic      negate_c;
    logic      force_a_one;
    logic      force_c_zero;
    logic      s3_valid;
    // modified operands
    bf16_t     a_mod;
    bf16_t     b_mod;
    bf16_t     c_mod;
    // special path, stage 2
    logic      special;
    fp32_t     special_result;
    logic      invalid;
    // stage 1 product
    wide_man_t prod_man;
    exp_t      prod_exp;
    logic      prod_sign;
    // stage 2 sum
    sum_man_t  sum_man;
    exp_t      sum_exp;
    logic      sum_sign;

    fma_control u_control (
        .gated_clk      (gated_clk),
        .reset          (reset),
        .in_valid_i     (in_valid_i),
        .op_code_i      (op_code_i),
        .out_credit_i   (out_credit_i),
        .in_credit_o    (in_credit_o),
        .negate_a_o     (negate_a),
        .negate_c_o     (negate_c),
        .force_a_one_o  (force_a_one),
        .force_c_zero_o (force_c_zero),
        .s3_valid_o     (s3_valid),
        .out_valid_o    (out_valid_o)
    );

    fma_classify u_classify (
        .gated_clk        (gated_clk),
        .reset            (reset),
        .op_a_i           (op_a_i),
        .op_b_i           (op_b_i),
        .op_c_i           (op_c_i),
        .negate_a_i       (negate_a),
        .negate_c_i       (negate_c),
        .force_a_one_i    (force_a_one),
        .force_c_zero_i   (force_c_zero),
        .a_o              (a_mod),
        .b_o              (b_mod),
        .c_o              (c_mod),
        .special_o        (special),
        .special_result_o (special_result),
        .invalid_o        (invalid)
    );

    fma_multiply u_multiply (
        .gated_clk   (gated_clk),
        .a_i         (a_mod),
        .b_i         (b_mod),
        .prod_man_o  (prod_man),
        .prod_exp_o  (prod_exp),
        .prod_sign_o (prod_sign)
    );

    fma_align_add u_align_add (
        .gated_clk   (gated_clk),
        .prod_man_i  (prod_man),
        .prod_exp_i  (prod_exp),
        .prod_sign_i (prod_sign),
        .c_i         (c_mod),
        .sum_man_o   (sum_man),
        .sum_exp_o   (sum_exp),
        .sum_sign_o  (sum_sign)
    );

    fma_normalize_round u_normalize_round (
        .gated_clk        (gated_clk),
        .reset            (reset),
        .s3_valid_i       (s3_valid),
        .sum_man_i        (sum_man),
        .sum_exp_i        (sum_exp),
        .sum_sign_i       (sum_sign),
        .special_i        (special),
        .special_result_i (special_result),
        .invalid_i        (invalid),
        .result_o         (result_o),
        .fpcsr_o          (fpcsr_o)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the fma_unit testbench with verilator

LOG=sim.log

verilator --binary --timing --assert --top-module fma_unit_tb \
    -f fma_unit.f -o fma_unit_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/fma_unit_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"
if grep -F -q '*** FAILED ***' "$LOG"; then
    exit 1
fi
if ! grep -F -q '*** PASSED ***' "$LOG"; then
    echo "no pass line in $LOG"
    exit 1
fi
exit 0

/* test/fma_unit_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module fma_unit_assertions (
    input  logic                      gated_clk,
    input  logic                      reset,
    input  logic                      in_valid_i,
    input  logic                      credit_grant_i,
    input  logic                      credit_return_i,
    input  logic                      out_valid_seen_i,
    input  fma_ctrl_pkg::credit_cnt_t credit_cnt_i
);
    import fma_ctrl_pkg::*;

    // counter stays within the sink depth
    credit_bound: assert property (@(posedge gated_clk) disable iff (!reset)
        credit_cnt_i <= credit_cnt_t'(RESULT_CREDITS))
        else $error("credit count above sink depth");

    // a grant with no slot coming back takes one from the count
    // an empty count would wrap and break the bound above
    grant_spends_credit: assert property (@(posedge gated_clk) disable iff (!reset)
        (credit_grant_i && !credit_return_i) |=> (credit_cnt_i == $past(credit_cnt_i) - 1'b1))
        else $error("credit granted without taking it from the count");

    // fixed four cycle latency, both directions
    valid_latency: assert property (@(posedge gated_clk) disable iff (!reset)
        out_valid_seen_i == $past(in_valid_i, PIPE_DEPTH))
        else $error("output valid not four cycles after input valid");

endmodule

// watch the control block from inside
bind fma_control fma_unit_assertions u_assertions (
    .gated_clk        (gated_clk),
    .reset            (reset),
    .in_valid_i       (in_valid_i),
    .credit_grant_i   (in_credit_o),
    .credit_return_i  (out_credit_i),
    .out_valid_seen_i (out_valid_o),
    .credit_cnt_i     (credit_cnt)
);

`default_nettype wire

/* test/fma_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fma_unit_tb;
    import bf16_pkg::*;
    import fma_ctrl_pkg::*;

    localparam int N_OPS      = 600;
    localparam int CLK_PERIOD = 8;
    // four cycles per op, plus slack for the slow sink
    localparam int TIMEOUT_NS = 4 * N_OPS * CLK_PERIOD + 2 * N_OPS * CLK_PERIOD + 1000;

    logic    gated_clk;
    logic    reset;
    logic    in_valid_i;
    bf16_t   op_a_i;
    bf16_t   op_b_i;
    bf16_t   op_c_i;
    fma_op_e op_code_i;
    logic    out_credit_i;
    logic    in_credit_o;
    logic    out_valid_o;
    fp32_t   result_o;
    fpcsr_t  fpcsr_o;

    int   seed = 32'hf263_2781;
    int   errors;
    int   checked;
    int   cycle;
    int   sent;
    int   held;
    int   grants;
    int   sc;
    logic running;
    logic [35:0] exp_word;
    // expected {fpcsr, result}, send cycles, sink release cycles
    logic [35:0] exp_q[$];
    int   sent_cyc_q[$];
    int   sink_q[$];
    // legal codes plus two unknown ones
    int   codes[9] = '{4, 5, 6, 7, 8, 9, 10, 0, 15};

    fma_unit dut0 (
        .gated_clk    (gated_clk),
        .reset        (reset),
        .in_valid_i   (in_valid_i),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .op_c_i       (op_c_i),
        .op_code_i    (op_code_i),
        .in_credit_o  (in_credit_o),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .result_o     (result_o),
        .fpcsr_o      (fpcsr_o)
    );

    initial begin
        gated_clk = 1'b0;
        forever #(CLK_PERIOD / 2) gated_clk = ~gated_clk;
    end

    // one draw in four is a special encoding
    function automatic logic [15:0] rand_operand();
        logic [15:0] v;
        logic [2:0]  pick;
        v    = 16'($random(seed));
        pick = 3'($random(seed));
        if (($random(seed) & 3) == 0) begin
            case (pick)
                3'd0: v[14:0] = 15'h0000;
                3'd1: v[14:0] = 15'h7F80;
                3'd2: v[14:0] = 15'h7FC0;
                3'd3: v[14:0] = 15'h0001;
                3'd4: v[14:0] = 15'h7F7F;
                3'd5: v[14:0] = 15'h0080;
                3'd6: v[14:0] = 15'h3F80;
                default: v[14:0] = 15'h7F81;
            endcase
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model, returns {invalid, overflow, underflow, inexact, result}
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [35:0] model_fma(input logic [15:0] a, input logic [15:0] b,
                                              input logic [15:0] c, input int op);
        logic [15:0] am;
        logic [15:0] cm;
        logic        nan_any;
        logic        ia;
        logic        ib;
        logic        ic;
        logic        ps;
        logic        sgn;
        logic [15:0] p;
        logic [31:0] pw;
        logic [31:0] cw;
        logic [32:0] raw;
        logic [33:0] s;
        logic [33:0] nrm;
        logic [23:0] mr;
        logic        g;
        logic        r;
        logic        st;
        int          ea;
        int          eb;
        int          ec;
        int          pe;
        int          big;
        int          lz;
        int          fe;
        am = a;
        cm = c;
        // add and sub put +1.0 in place of a
        if (op == 4 || op == 6) am = 16'h3F80;
        else if (op == 9 || op == 10) am[15] = ~am[15];
        if (op == 5 || (c[14:7] == 8'h00 && c[6:0] != 7'h00)) cm = 16'h0000;
        else if (op == 6 || op == 8 || op == 9) cm[15] = ~cm[15];
        ea = int'(am[14:7]);
        eb = int'(b[14:7]);
        ec = int'(cm[14:7]);
        nan_any = (ea == 255 && am[6:0] != 0) || (eb == 255 && b[6:0] != 0)
                  || (ec == 255 && cm[6:0] != 0);
        ia = (ea == 255 && am[6:0] == 0);
        ib = (eb == 255 && b[6:0] == 0);
        ic = (ec == 255 && cm[6:0] == 0);
        ps = am[15] ^ b[15];
        // special cases first
        if (nan_any || (ia && eb == 0) || (ib && ea == 0) || ((ia || ib) && ic && ps != cm[15]))
            return {4'b1000, 32'h7FC0_0000};
        if (ia || ib) return {4'b0000, ps, 8'hFF, 23'h0};
        if (ic) return {4'b0000, cm[15], 8'hFF, 23'h0};
        if (ea == 0 || eb == 0) return {4'b0000, cm, 16'h0000};
        // product, flushed when the exponent is not positive
        p  = 16'({1'b1, am[6:0]}) * 16'({1'b1, b[6:0]});
        pe = ea + eb - 127;
        if (pe <= 0) begin
            p  = 16'h0;
            pe = 0;
        end
        if (p[15]) pe = pe + 1;
        else p = p << 1;
        pw = {p, 16'h0000};
        cw = {ec != 0, cm[6:0], 24'h0};
        // align, truncating whatever falls off
        if (ec < pe) begin
            cw  = cw >> (pe - ec);
            big = pe;
        end else begin
            pw  = pw >> (ec - pe);
            big = ec;
        end
        if (ps != cm[15]) begin
            raw = (pw >= cw) ? {1'b0, pw - cw} : {1'b0, cw - pw};
            sgn = (pw >= cw) ? ps : cm[15];
        end else begin
            raw = {1'b0, pw} + {1'b0, cw};
            sgn = ps;
        end
        s = {raw, 1'b0};
        if (s[33]) begin
            s   = s >> 1;
            big = big + 1;
        end else if (s == 34'h0) begin
            big = 0;
        end
        // leading one to bit 32
        lz = 33;
        for (int i = 0; i <= 32; i++) begin
            if (s[i]) lz = 32 - i;
        end
        nrm = s << lz;
        fe  = big - lz;
        g   = nrm[8];
        r   = nrm[7];
        st  = |nrm[6:0];
        mr  = {1'b0, nrm[31:9]} + 24'(g & (r | st | nrm[9]));
        if (mr[23]) fe = fe + 1;
        if (fe >= 255) return {3'b010, g | r | st, sgn, 8'hFF, 23'h0};
        if (fe <= 0) return {4'b0011, sgn, 31'h0};
        return {3'b000, g | r | st, sgn, 8'(fe), mr[22:0]};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // per cycle upstream, sink and checks
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge gated_clk) begin
        cycle = cycle + 1;
        if (running) begin
            if (out_valid_o) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("result came out with nothing in flight, cycle %0d", cycle);
                end
                if (exp_q.size() > 0) begin
                    exp_word = exp_q.pop_front();
                    sc       = sent_cyc_q.pop_front();
                    checked++;
                    assert (result_o === exp_word[31:0]) else begin
                        errors++;
                        $display("error: result op %0d expected %h actual %h",
                                 checked, exp_word[31:0], result_o);
                    end
                    assert (fpcsr_o === exp_word[35:32]) else begin
                        errors++;
                        $display("error: fpcsr op %0d expected %b actual %b",
                                 checked, exp_word[35:32], fpcsr_o);
                    end
                    assert (cycle == sc + PIPE_DEPTH) else begin
                        errors++;
                        $display("error: latency op %0d expected %0d actual %0d",
                                 checked, PIPE_DEPTH, cycle - sc);
                    end
                    // slow sink frees the slot later
                    sink_q.push_back(cycle + 1 + ($random(seed) & 7));
                end
            end
            out_credit_i = 1'b0;
            if (sink_q.size() > 0 && sink_q[0] <= cycle) begin
                void'(sink_q.pop_front());
                out_credit_i = 1'b1;
            end
            // send only on a credit from an earlier cycle
            in_valid_i = 1'b0;
            if (sent < N_OPS && held > 0 && ($random(seed) & 3) != 0) begin
                op_a_i     = rand_operand();
                op_b_i     = rand_operand();
                op_c_i     = rand_operand();
                op_code_i  = fma_op_e'(codes[$unsigned($random(seed)) % 9]);
                in_valid_i = 1'b1;
                held--;
                sent++;
                exp_q.push_back(model_fma(op_a_i, op_b_i, op_c_i, int'(op_code_i)));
                sent_cyc_q.push_back(cycle);
            end
            if (in_credit_o) held++;
            assert (held + exp_q.size() + sink_q.size() <= RESULT_CREDITS) else begin
                errors++;
                $display("more items outstanding than credits, cycle %0d", cycle);
            end
        end
    end

    initial begin
        reset        = 1'b0;
        in_valid_i   = 1'b0;
        op_a_i       = '0;
        op_b_i       = '0;
        op_c_i       = '0;
        op_code_i    = FMADD;
        out_credit_i = 1'b0;
        running      = 1'b0;
        errors       = 0;
        checked      = 0;
        cycle        = 0;
        sent         = 0;
        held         = 0;
        grants       = 0;
        repeat (10) @(negedge gated_clk);
        reset = 1'b1;
        // no slots returned yet, so exactly the sink depth is granted
        // first grant is already live in the release cycle
        repeat (12) begin
            if (in_credit_o) grants++;
            @(negedge gated_clk);
        end
        assert (grants == RESULT_CREDITS) else begin
            errors++;
            $display("error: reset grants expected %0d actual %0d", RESULT_CREDITS, grants);
        end
        // nothing sent yet, outputs still at their reset values
        assert (result_o === '0 && fpcsr_o === '0 && out_valid_o === 1'b0) else begin
            errors++;
            $display("outputs not zero after reset");
        end
        @(posedge gated_clk);
        held    = grants;
        running = 1'b1;
        wait (sent == N_OPS && exp_q.size() == 0);
        repeat (4) @(negedge gated_clk);
        $display("%0d results checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: not all results arrived, %0d of %0d checked", checked, N_OPS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
